// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/100ps -f vlog.f --top-module fabricTb -o fabricSim

run: compile
	./obj_dir/fabricSim > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Errors found" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "No errors" sim.log; then echo "Simulation gave no result"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

// ==== design/apertureDecoder.sv ====
// Aperture decoder
// Splits the host bus into one select per block, fans out the
// request and merges acknowledges and read data on the way back

module apertureDecoder
(
    input  logic [fabricPkg::adrWidth-1:0]   wbsAdr_i,
    input  logic                             wbsCyc_i,
    input  logic                             wbsStb_i,
    input  logic                             wbsWe_i,
    input  logic [fabricPkg::byteLanes-1:0]  wbsByteStb_i,
    input  logic [fabricPkg::dataWidth-1:0]  wbsWrDat_i,
    output logic [fabricPkg::dataWidth-1:0]  wbsRdDat_o,
    output logic                             wbsAck_o,

    fabricBusIf.decoder                      regBus_o,
    fabricBusIf.decoder                      ramBus_o,
    fabricBusIf.decoder                      resBus_o,
    fabricBusIf.decoder                      missBus_o
);

    logic [fabricPkg::apertureMsb-fabricPkg::apertureLsb:0] aperture;
    logic regSel;
    logic ramSel;
    logic resSel;
    logic missSel;

    // ------------------------------------------------------------
    // Block selects
    // ------------------------------------------------------------
    assign aperture = wbsAdr_i[fabricPkg::apertureMsb:fabricPkg::apertureLsb];

    assign regSel  = (aperture == fabricPkg::regAperture);
    assign ramSel  = (aperture == fabricPkg::ramAperture);
    assign resSel  = (aperture == fabricPkg::reservedAperture);
    assign missSel = !(regSel || ramSel || resSel);

    assign regBus_o.cyc  = wbsCyc_i && regSel;
    assign ramBus_o.cyc  = wbsCyc_i && ramSel;
    assign resBus_o.cyc  = wbsCyc_i && resSel;
    assign missBus_o.cyc = wbsCyc_i && missSel;

    // Same request fan-out for every block
    assign regBus_o.stb     = wbsStb_i;
    assign regBus_o.we      = wbsWe_i;
    assign regBus_o.adr     = wbsAdr_i;
    assign regBus_o.byteStb = wbsByteStb_i;
    assign regBus_o.wrDat   = wbsWrDat_i;

    assign ramBus_o.stb     = wbsStb_i;
    assign ramBus_o.we      = wbsWe_i;
    assign ramBus_o.adr     = wbsAdr_i;
    assign ramBus_o.byteStb = wbsByteStb_i;
    assign ramBus_o.wrDat   = wbsWrDat_i;

    assign resBus_o.stb     = wbsStb_i;
    assign resBus_o.we      = wbsWe_i;
    assign resBus_o.adr     = wbsAdr_i;
    assign resBus_o.byteStb = wbsByteStb_i;
    assign resBus_o.wrDat   = wbsWrDat_i;

    assign missBus_o.stb     = wbsStb_i;
    assign missBus_o.we      = wbsWe_i;
    assign missBus_o.adr     = wbsAdr_i;
    assign missBus_o.byteStb = wbsByteStb_i;
    assign missBus_o.wrDat   = wbsWrDat_i;

    // ------------------------------------------------------------
    // Response merge
    // ------------------------------------------------------------
    assign wbsAck_o = regBus_o.ack | ramBus_o.ack | resBus_o.ack | missBus_o.ack;

    always_comb
    begin
        case (aperture)
            fabricPkg::regAperture:      wbsRdDat_o = regBus_o.rdDat;
            fabricPkg::ramAperture:      wbsRdDat_o = ramBus_o.rdDat;
            fabricPkg::reservedAperture: wbsRdDat_o = resBus_o.rdDat;
            default:                     wbsRdDat_o = fabricPkg::badAccessValue;
        endcase
    end

endmodule

// ==== design/fabricBusIf.sv ====
// Fabric block bus
// One block's share of the host bus: request from the decoder,
// read data and acknowledge back from the block

interface fabricBusIf;

    // Request side, driven by the aperture decoder
    logic                             cyc;
    logic                             stb;
    logic                             we;
    logic [fabricPkg::byteLanes-1:0]  byteStb;
    logic [fabricPkg::dataWidth-1:0]  wrDat;
    logic [fabricPkg::adrWidth-1:0]   adr;

    // Response side, driven by the block
    logic [fabricPkg::dataWidth-1:0]  rdDat;
    logic                             ack;

    modport decoder
    (
        output cyc, stb, we, byteStb, wrDat, adr,
        input  rdDat, ack
    );

    modport target
    (
        input  cyc, stb, we, byteStb, wrDat, adr,
        output rdDat, ack
    );

endinterface

// ==== design/fabricPkg.sv ====
// Fabric IP shared definitions
// Bus widths, aperture map, register offsets, identification values
// and the timeout state type of the unmapped-access handler

package fabricPkg;

    // ------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------
    localparam int adrWidth  = 17;
    localparam int dataWidth = 32;
    localparam int byteLanes = 4;

    // Aperture field sits in the top address bits
    localparam int apertureMsb = 16;
    localparam int apertureLsb = 13;

    localparam logic [apertureMsb-apertureLsb:0] regAperture      = 4'h0;
    localparam logic [apertureMsb-apertureLsb:0] ramAperture      = 4'h1;
    localparam logic [apertureMsb-apertureLsb:0] reservedAperture = 4'h6;

    // Word offsets start at address bit 2
    localparam int regAdrWidth = 7;
    localparam int ramAdrWidth = 11;

    // ------------------------------------------------------------
    // Register block
    // ------------------------------------------------------------
    localparam logic [regAdrWidth-1:0] regIdAdr      = 7'h0;
    localparam logic [regAdrWidth-1:0] regRevAdr     = 7'h1;
    localparam logic [regAdrWidth-1:0] regGpioInAdr  = 7'h2;
    localparam logic [regAdrWidth-1:0] regGpioOutAdr = 7'h3;
    localparam logic [regAdrWidth-1:0] regGpioOeAdr  = 7'h4;

    localparam logic [dataWidth-1:0] fabricIdValue  = 32'h0000_5A31;
    localparam logic [dataWidth-1:0] fabricRevValue = 32'h0000_0100;
    localparam int gpioWidth = 8;

    // ------------------------------------------------------------
    // Reserved block
    // ------------------------------------------------------------
    localparam logic [regAdrWidth-1:0] resCustProdAdr  = 7'h7E;
    localparam logic [regAdrWidth-1:0] resRevisionsAdr = 7'h7F;

    localparam logic [7:0]  customerId = 8'h01;
    localparam logic [7:0]  productId  = 8'h00;
    localparam logic [15:0] majorRev   = 16'h0001;
    localparam logic [15:0] minorRev   = 16'h0000;

    // Read words for undefined places
    localparam logic [dataWidth-1:0] regDefValue    = 32'hFABDEFAC;
    localparam logic [dataWidth-1:0] resDefValue    = 32'hDEFFABAC;
    localparam logic [dataWidth-1:0] badAccessValue = 32'hBADFABAC;

    // Unmapped access timeout
    localparam int timeoutCntWidth = 3;
    localparam logic [timeoutCntWidth-1:0] timeoutLimit = 3'd7;

    typedef enum logic {toIdle, toCount} timeoutState_t;

endpackage

// ==== design/fabricRam.sv ====
// Fabric word RAM
// 2048 x 32 memory with byte-lane writes and a registered read,
// acknowledged one cycle after the request is seen

module fabricRam
(
    input  logic        wbClk_i,
    input  logic        arstN_i,
    fabricBusIf.target  bus_i
);

    logic [fabricPkg::dataWidth-1:0] mem [(1 << fabricPkg::ramAdrWidth)-1:0];

    logic [fabricPkg::ramAdrWidth-1:0] wordAdr;
    logic                              access;
    logic                              ackQ;
    logic [fabricPkg::dataWidth-1:0]   rdDatQ;

    assign wordAdr = bus_i.adr[fabricPkg::ramAdrWidth+1:2];

    // First edge of a held request only
    assign access = bus_i.cyc && bus_i.stb && !ackQ;

    always_ff @(posedge wbClk_i or negedge arstN_i)
    begin
        if (!arstN_i)
            ackQ <= 1'b0;
        else
            ackQ <= access;
    end

    // ------------------------------------------------------------
    // Memory array with byte-lane writes
    // ------------------------------------------------------------
    always_ff @(posedge wbClk_i)
    begin
        if (access)
        begin
            rdDatQ <= mem[wordAdr];
            if (bus_i.we)
            begin
                for (int lane = 0; lane < fabricPkg::byteLanes; lane++)
                begin
                    if (bus_i.byteStb[lane])
                        mem[wordAdr][lane*8 +: 8] <= bus_i.wrDat[lane*8 +: 8];
                end
            end
        end
    end

    assign bus_i.rdDat = rdDatQ;
    assign bus_i.ack   = ackQ;

endmodule

// ==== design/fabricRegisters.sv ====
// Fabric register block
// ID and revision words plus GPIO input, output and output-enable
// registers, with a one-cycle acknowledge per access

module fabricRegisters
(
    input  logic                             wbClk_i,
    input  logic                             arstN_i,
    fabricBusIf.target                       bus_i,
    input  logic [fabricPkg::gpioWidth-1:0]  gpioIn_i,
    output logic [fabricPkg::gpioWidth-1:0]  gpioOut_o,
    output logic [fabricPkg::gpioWidth-1:0]  gpioOe_o
);

    logic [fabricPkg::regAdrWidth-1:0] offset;
    logic                              req;
    logic                              wrEn;
    logic                              ackQ;
    logic [fabricPkg::gpioWidth-1:0]   gpioInQ;
    logic [fabricPkg::gpioWidth-1:0]   gpioOutQ;
    logic [fabricPkg::gpioWidth-1:0]   gpioOeQ;

    assign offset = bus_i.adr[fabricPkg::regAdrWidth+1:2];
    assign req    = bus_i.cyc && bus_i.stb;

    // GPIO registers only take byte lane 0
    assign wrEn = req && !ackQ && bus_i.we && bus_i.byteStb[0];

    // ------------------------------------------------------------
    // Acknowledge and GPIO output registers
    // ------------------------------------------------------------
    always_ff @(posedge wbClk_i or negedge arstN_i)
    begin
        if (!arstN_i)
        begin
            ackQ     <= 1'b0;
            gpioOutQ <= '0;
            gpioOeQ  <= '0;
        end
        else
        begin
            // High for one cycle, then wait for the host to drop stb
            ackQ <= req && !ackQ;

            if (wrEn)
            begin
                case (offset)
                    fabricPkg::regGpioOutAdr: gpioOutQ <= bus_i.wrDat[fabricPkg::gpioWidth-1:0];
                    fabricPkg::regGpioOeAdr:  gpioOeQ  <= bus_i.wrDat[fabricPkg::gpioWidth-1:0];
                    default:                  ;
                endcase
            end
        end
    end

    // Input pins sampled every cycle
    always_ff @(posedge wbClk_i)
    begin
        gpioInQ <= gpioIn_i;
    end

    // ------------------------------------------------------------
    // Read data
    // ------------------------------------------------------------
    always_comb
    begin
        case (offset)
            fabricPkg::regIdAdr:      bus_i.rdDat = fabricPkg::fabricIdValue;
            fabricPkg::regRevAdr:     bus_i.rdDat = fabricPkg::fabricRevValue;
            fabricPkg::regGpioInAdr:
            begin
                bus_i.rdDat = {{(fabricPkg::dataWidth-fabricPkg::gpioWidth){1'b0}}, gpioInQ};
            end
            fabricPkg::regGpioOutAdr:
            begin
                bus_i.rdDat = {{(fabricPkg::dataWidth-fabricPkg::gpioWidth){1'b0}}, gpioOutQ};
            end
            fabricPkg::regGpioOeAdr:
            begin
                bus_i.rdDat = {{(fabricPkg::dataWidth-fabricPkg::gpioWidth){1'b0}}, gpioOeQ};
            end
            default:                  bus_i.rdDat = fabricPkg::regDefValue;
        endcase
    end

    assign bus_i.ack = ackQ;
    assign gpioOut_o = gpioOutQ;
    assign gpioOe_o  = gpioOeQ;

endmodule

// ==== design/fabricTop.sv ====
// Fabric IP top level
// Wishbone-style target serving the register block, the word RAM
// and the reserved identification block behind one aperture decoder

module fabricTop
(
    input  logic                             wbClk_i,
    input  logic                             arstN_i,

    // Host bus
    input  logic [fabricPkg::adrWidth-1:0]   wbsAdr_i,
    input  logic                             wbsCyc_i,
    input  logic                             wbsStb_i,
    input  logic                             wbsWe_i,
    input  logic [fabricPkg::byteLanes-1:0]  wbsByteStb_i,
    input  logic [fabricPkg::dataWidth-1:0]  wbsWrDat_i,
    output logic [fabricPkg::dataWidth-1:0]  wbsRdDat_o,
    output logic                             wbsAck_o,

    // GPIO
    input  logic [fabricPkg::gpioWidth-1:0]  gpioIn_i,
    output logic [fabricPkg::gpioWidth-1:0]  gpioOut_o,
    output logic [fabricPkg::gpioWidth-1:0]  gpioOe_o
);

    fabricBusIf regBus ();
    fabricBusIf ramBus ();
    fabricBusIf resBus ();
    fabricBusIf missBus ();

    // ------------------------------------------------------------
    // Address decode and response merge
    // ------------------------------------------------------------
    apertureDecoder i_apertureDecoder
    (
        .wbsAdr_i     (wbsAdr_i),
        .wbsCyc_i     (wbsCyc_i),
        .wbsStb_i     (wbsStb_i),
        .wbsWe_i      (wbsWe_i),
        .wbsByteStb_i (wbsByteStb_i),
        .wbsWrDat_i   (wbsWrDat_i),
        .wbsRdDat_o   (wbsRdDat_o),
        .wbsAck_o     (wbsAck_o),
        .regBus_o     (regBus),
        .ramBus_o     (ramBus),
        .resBus_o     (resBus),
        .missBus_o    (missBus)
    );

    // ------------------------------------------------------------
    // Target blocks
    // ------------------------------------------------------------
    fabricRegisters i_fabricRegisters
    (
        .wbClk_i   (wbClk_i),
        .arstN_i   (arstN_i),
        .bus_i     (regBus),
        .gpioIn_i  (gpioIn_i),
        .gpioOut_o (gpioOut_o),
        .gpioOe_o  (gpioOe_o)
    );

    fabricRam i_fabricRam
    (
        .wbClk_i (wbClk_i),
        .arstN_i (arstN_i),
        .bus_i   (ramBus)
    );

    // Also answers accesses that hit no aperture
    reservedBlock i_reservedBlock
    (
        .wbClk_i   (wbClk_i),
        .arstN_i   (arstN_i),
        .resBus_i  (resBus),
        .missBus_i (missBus)
    );

endmodule

// ==== design/reservedBlock.sv ====
// Reserved identification block
// Customer/product and revision words, and the timeout machine
// that acknowledges accesses outside every aperture

module reservedBlock
(
    input  logic        wbClk_i,
    input  logic        arstN_i,
    fabricBusIf.target  resBus_i,
    fabricBusIf.target  missBus_i
);

    logic [fabricPkg::regAdrWidth-1:0]     offset;
    logic                                  resReq;
    logic                                  resAckQ;
    logic                                  missReq;
    logic                                  missAckQ;
    logic [fabricPkg::timeoutCntWidth-1:0] toCnt;
    fabricPkg::timeoutState_t              toState;

    // ------------------------------------------------------------
    // Identification words
    // ------------------------------------------------------------
    assign offset = resBus_i.adr[fabricPkg::regAdrWidth+1:2];
    assign resReq = resBus_i.cyc && resBus_i.stb;

    always_comb
    begin
        case (offset)
            fabricPkg::resCustProdAdr:
                resBus_i.rdDat = {16'h0000, fabricPkg::customerId, fabricPkg::productId};
            fabricPkg::resRevisionsAdr:
                resBus_i.rdDat = {fabricPkg::majorRev, fabricPkg::minorRev};
            default:
                resBus_i.rdDat = fabricPkg::resDefValue;
        endcase
    end

    // ------------------------------------------------------------
    // Acknowledges and timeout machine
    // ------------------------------------------------------------
    assign missReq = missBus_i.cyc && missBus_i.stb;

    always_ff @(posedge wbClk_i or negedge arstN_i)
    begin
        if (!arstN_i)
        begin
            resAckQ  <= 1'b0;
            missAckQ <= 1'b0;
            toCnt    <= '0;
            toState  <= fabricPkg::toIdle;
        end
        else
        begin
            // Writes to the reserved words have no effect
            resAckQ  <= resReq && !resAckQ;
            missAckQ <= 1'b0;

            case (toState)
                fabricPkg::toIdle:
                begin
                    // Skip the cycle in which the last miss is still acknowledged
                    if (missReq && !missAckQ)
                    begin
                        toState <= fabricPkg::toCount;
                        toCnt   <= 3'd1;
                    end
                end
                fabricPkg::toCount:
                begin
                    if (!missReq)
                    begin
                        toState <= fabricPkg::toIdle;
                        toCnt   <= '0;
                    end
                    else if (toCnt == fabricPkg::timeoutLimit)
                    begin
                        missAckQ <= 1'b1;
                        toState  <= fabricPkg::toIdle;
                        toCnt    <= '0;
                    end
                    else
                        toCnt <= toCnt + 3'd1;
                end
                default:
                    toState <= fabricPkg::toIdle;
            endcase
        end
    end

    assign resBus_i.ack  = resAckQ;
    assign missBus_i.ack = missAckQ;

endmodule

// ==== test/fabricTb.sv ====
// Fabric IP testbench
// Applies a table of bus accesses to the fabric top level and checks
// read data, acknowledge delay and the GPIO outputs after each access

module fabricTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int maxRows  = 40;
    localparam int ackLimit = 12;

    // Expected words of the fabric map
    localparam logic [31:0] idWord        = 32'h0000_5A31;
    localparam logic [31:0] revWord       = 32'h0000_0100;
    localparam logic [31:0] regDefault    = 32'hFABD_EFAC;
    localparam logic [31:0] custProdWord  = 32'h0000_0100;
    localparam logic [31:0] revisionsWord = 32'h0001_0000;
    localparam logic [31:0] resDefault    = 32'hDEFF_ABAC;
    localparam logic [31:0] badAccess     = 32'hBADF_ABAC;

    logic        wbClk;
    logic        arstN;
    logic [16:0] wbsAdr;
    logic        wbsCyc;
    logic        wbsStb;
    logic        wbsWe;
    logic [3:0]  wbsByteStb;
    logic [31:0] wbsWrDat;
    logic [31:0] wbsRdDat;
    logic        wbsAck;
    logic [7:0]  gpioIn;
    logic [7:0]  gpioOut;
    logic [7:0]  gpioOe;

    // Stimulus table with one entry per access
    string       rowName   [maxRows];
    logic        rowWe     [maxRows];
    logic [16:0] rowAdr    [maxRows];
    logic [3:0]  rowStb    [maxRows];
    logic [31:0] rowWrDat  [maxRows];
    logic [31:0] rowExpRd  [maxRows];
    int          rowDelay  [maxRows];
    logic [7:0]  rowExpOut [maxRows];
    logic [7:0]  rowExpOe  [maxRows];
    int          numRows;

    logic [16:0] lfsr;
    logic [31:0] ramShadow [int];
    logic [7:0]  gpioOutModel;
    logic [7:0]  gpioOeModel;
    int          cycleCount;
    int          cycleLimit;
    int          errorCount;
    int          failedTests;

    fabricTop i_dut
    (
        .wbClk_i      (wbClk),
        .arstN_i      (arstN),
        .wbsAdr_i     (wbsAdr),
        .wbsCyc_i     (wbsCyc),
        .wbsStb_i     (wbsStb),
        .wbsWe_i      (wbsWe),
        .wbsByteStb_i (wbsByteStb),
        .wbsWrDat_i   (wbsWrDat),
        .wbsRdDat_o   (wbsRdDat),
        .wbsAck_o     (wbsAck),
        .gpioIn_i     (gpioIn),
        .gpioOut_o    (gpioOut),
        .gpioOe_o     (gpioOe)
    );

    always #50 wbClk = ~wbClk;

    // 17-bit Fibonacci LFSR with taps 17 and 14
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[16] ^ lfsr[13];
            lfsr = {lfsr[15:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [16:0] regAdr(input logic [6:0] off);
        return {4'h0, 4'h0, off, 2'b00};
    endfunction

    function automatic logic [16:0] resAdr(input logic [6:0] off);
        return {4'h6, 4'h0, off, 2'b00};
    endfunction

    // ------------------------------------------------------------
    // Table construction
    // ------------------------------------------------------------
    task automatic addRow(input string name, input logic we, input logic [16:0] adr,
                          input logic [3:0] bs, input logic [31:0] dat,
                          input logic [31:0] expRd, input int dly);
        rowName[numRows]   = name;
        rowWe[numRows]     = we;
        rowAdr[numRows]    = adr;
        rowStb[numRows]    = bs;
        rowWrDat[numRows]  = dat;
        rowExpRd[numRows]  = expRd;
        rowDelay[numRows]  = dly;
        rowExpOut[numRows] = gpioOutModel;
        rowExpOe[numRows]  = gpioOeModel;
        numRows++;
    endtask

    // GPIO registers take lane 0 only
    task automatic regWrite(input string name, input logic [6:0] off, input logic [3:0] bs);
        logic [31:0] dat;
        dat = randBits(32);
        if (bs[0] && off == 7'd3)
            gpioOutModel = dat[7:0];
        if (bs[0] && off == 7'd4)
            gpioOeModel = dat[7:0];
        addRow(name, 1'b1, regAdr(off), bs, dat, 32'h0, 1);
    endtask

    task automatic ramWrite(input string name, input logic [10:0] w, input logic [3:0] bs);
        logic [31:0] dat;
        logic [31:0] merged;
        dat    = randBits(32);
        merged = ramShadow.exists(int'(w)) ? ramShadow[int'(w)] : 32'h0;
        for (int lane = 0; lane < 4; lane++)
        begin
            if (bs[lane])
                merged[lane*8 +: 8] = dat[lane*8 +: 8];
        end
        ramShadow[int'(w)] = merged;
        addRow(name, 1'b1, {4'h1, w, 2'b00}, bs, dat, 32'h0, 1);
    endtask

    task automatic buildTable();
        logic [31:0] tmp;
        logic [10:0] w;
        logic [3:0]  bs;
        addRow("rdId", 1'b0, regAdr(7'd0), 4'hF, 32'h0, idWord, 1);
        addRow("rdRev", 1'b0, regAdr(7'd1), 4'hF, 32'h0, revWord, 1);
        addRow("rdRegUndef", 1'b0, regAdr(7'd5), 4'hF, 32'h0, regDefault, 1);
        regWrite("wrGpioOut", 7'd3, 4'b0001);
        regWrite("wrGpioOe", 7'd4, 4'b0001);
        addRow("rdGpioOut", 1'b0, regAdr(7'd3), 4'hF, 32'h0, {24'h0, gpioOutModel}, 1);
        addRow("rdGpioOe", 1'b0, regAdr(7'd4), 4'hF, 32'h0, {24'h0, gpioOeModel}, 1);
        regWrite("wrGpioOutHi", 7'd3, 4'b1110);
        regWrite("wrGpioOeHi", 7'd4, 4'b1110);
        addRow("rdGpioOutHi", 1'b0, regAdr(7'd3), 4'hF, 32'h0, {24'h0, gpioOutModel}, 1);
        addRow("rdGpioOeHi", 1'b0, regAdr(7'd4), 4'hF, 32'h0, {24'h0, gpioOeModel}, 1);
        addRow("rdGpioIn", 1'b0, regAdr(7'd2), 4'hF, 32'h0, {24'h0, gpioIn}, 1);
        // Full word first so no lane stays unknown
        for (int i = 0; i < 4; i++)
        begin
            tmp = randBits(11);
            w   = tmp[10:0];
            tmp = randBits(4);
            bs  = tmp[3:0];
            if (bs == 4'h0 || bs == 4'hF)
                bs = 4'b0101;
            ramWrite($sformatf("ramFull%0d", i), w, 4'hF);
            ramWrite($sformatf("ramPart%0d", i), w, bs);
            addRow($sformatf("ramRead%0d", i), 1'b0, {4'h1, w, 2'b00}, 4'hF, 32'h0,
                   ramShadow[int'(w)], 1);
        end
        addRow("rdCustProd", 1'b0, resAdr(7'h7E), 4'hF, 32'h0, custProdWord, 1);
        addRow("rdRevisions", 1'b0, resAdr(7'h7F), 4'hF, 32'h0, revisionsWord, 1);
        addRow("rdResUndef", 1'b0, resAdr(7'h04), 4'hF, 32'h0, resDefault, 1);
        addRow("wrCustProd", 1'b1, resAdr(7'h7E), 4'hF, randBits(32), 32'h0, 1);
        addRow("wrRevisions", 1'b1, resAdr(7'h7F), 4'hF, randBits(32), 32'h0, 1);
        addRow("rdCustProd2", 1'b0, resAdr(7'h7E), 4'hF, 32'h0, custProdWord, 1);
        addRow("rdRevisions2", 1'b0, resAdr(7'h7F), 4'hF, 32'h0, revisionsWord, 1);
        addRow("rdMiss", 1'b0, {4'h3, 11'h010, 2'b00}, 4'hF, 32'h0, badAccess, 8);
        addRow("wrMiss", 1'b1, {4'h3, 11'h020, 2'b00}, 4'hF, randBits(32), 32'h0, 8);
        addRow("rdIdAfterMiss", 1'b0, regAdr(7'd0), 4'hF, 32'h0, idWord, 1);
    endtask

    // ------------------------------------------------------------
    // Bus access held until acknowledge
    // ------------------------------------------------------------
    task automatic busAccess(input int r, output logic [31:0] rd, output int delay,
                             output bit acked);
        wbsAdr     = rowAdr[r];
        wbsWe      = rowWe[r];
        wbsByteStb = rowStb[r];
        wbsWrDat   = rowWrDat[r];
        wbsCyc     = 1'b1;
        wbsStb     = 1'b1;
        delay      = 0;
        acked      = 1'b0;
        rd         = '0;
        while (!acked && delay < ackLimit)
        begin
            @(posedge wbClk);
            #10;
            delay++;
            if (wbsAck)
            begin
                acked = 1'b1;
                rd    = wbsRdDat;
            end
        end
        wbsCyc = 1'b0;
        wbsStb = 1'b0;
        wbsWe  = 1'b0;
        // One idle cycle before the next request
        @(posedge wbClk);
        #10;
    endtask

    always @(posedge wbClk)
    begin
        cycleCount++;
        if (cycleCount >= cycleLimit)
        begin
            $display("Run stopped after %0d cycles without finishing", cycleCount);
            $display("Errors found");
            $finish;
        end
    end

    initial
    begin
        logic [31:0] rd;
        logic [31:0] tmp;
        int          delay;
        bit          acked;
        int          rowErrors;
        wbClk        = 1'b0;
        arstN        = 1'b0;
        wbsAdr       = '0;
        wbsCyc       = 1'b0;
        wbsStb       = 1'b0;
        wbsWe        = 1'b0;
        wbsByteStb   = '0;
        wbsWrDat     = '0;
        lfsr         = 17'd86806;
        numRows      = 0;
        errorCount   = 0;
        failedTests  = 0;
        cycleCount   = 0;
        gpioOutModel = '0;
        gpioOeModel  = '0;
        tmp          = randBits(8);
        gpioIn       = tmp[7:0];
        buildTable();
        cycleLimit = numRows * ackLimit + 20;

        repeat (3) @(posedge wbClk);
        #10;
        arstN = 1'b1;

        for (int r = 0; r < numRows; r++)
        begin
            rowErrors = 0;
            busAccess(r, rd, delay, acked);
            if (!acked)
            begin
                $display("%s: no acknowledge within %0d cycles", rowName[r], ackLimit);
                rowErrors++;
            end
            else
            begin
                if (rowDelay[r] != 0 && delay != rowDelay[r])
                begin
                    $display("ERROR %s ack delay: expected %0d, actual %0d",
                             rowName[r], rowDelay[r], delay);
                    rowErrors++;
                end
                if (!rowWe[r] && rd !== rowExpRd[r])
                begin
                    $display("ERROR %s read: expected %h, actual %h", rowName[r], rowExpRd[r], rd);
                    rowErrors++;
                end
            end
            if (gpioOut !== rowExpOut[r])
            begin
                $display("ERROR %s gpioOut: expected %h, actual %h",
                         rowName[r], rowExpOut[r], gpioOut);
                rowErrors++;
            end
            if (gpioOe !== rowExpOe[r])
            begin
                $display("ERROR %s gpioOe: expected %h, actual %h", rowName[r], rowExpOe[r], gpioOe);
                rowErrors++;
            end
            if (rowErrors == 0)
                $display("%-14s passed", rowName[r]);
            else
            begin
                $display("%-14s failed", rowName[r]);
                failedTests++;
            end
            errorCount += rowErrors;
        end

        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 numRows, numRows - failedTests, failedTests);
        if (errorCount == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== vlog.f ====
design/fabricPkg.sv
design/fabricBusIf.sv
design/apertureDecoder.sv
design/fabricRegisters.sv
design/fabricRam.sv
design/reservedBlock.sv
design/fabricTop.sv
test/fabricTb.sv
